// File: nes_loader.f
+incdir+rtl
+incdir+tb
rtl/ines_pkg.sv
rtl/loader_pkg.sv
rtl/ines_header_decoder.sv
rtl/rom_load_sequencer.sv
rtl/mem_write_merge.sv
rtl/nes_loader.sv
tb/tb_nes_loader.sv

// File: rtl/ines_header_decoder.sv
//******************************
// iNES header decoder: header byte store, magic
// classification and mapper flag word
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "nes_loader_macros.svh"

module ines_header_decoder
	import ines_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic [7:0]    dl_data,
	input  logic          hdr_wr,
	input  logic [3:0]    hdr_count,
	input  logic          seq_finish,
	input  logic          invert_mirroring,
	output hdr_kind_t     hdr_kind,
	output logic [7:0]    prg_pages,
	output logic [7:0]    chr_pages,
	output logic          trainer,
	output mapper_flags_t mapper_flags
);

	logic [7:0] hdr_bytes [`HDR_LEN];
	logic upper_nonzero;
	logic is_nes20;
	logic is_dirty;
	mapper_flags_t flags_stored;
	mapper_flags_t flags_fds;

	// Round a page count up to a power of two, as a log2 code
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		if (pages <= 8'd1) return 3'd0;
		else if (pages <= 8'd2) return 3'd1;
		else if (pages <= 8'd4) return 3'd2;
		else if (pages <= 8'd8) return 3'd3;
		else if (pages <= 8'd16) return 3'd4;
		else if (pages <= 8'd32) return 3'd5;
		else if (pages <= 8'd64) return 3'd6;
		else return 3'd7;
	endfunction

	function automatic mapper_flags_t build_flags(input logic [7:0] b4, input logic [7:0] b5,
			input logic [7:0] b6, input logic [7:0] b7, input logic dirty, input logic inv);
		logic [7:0] mapper;
		mapper = {dirty ? 4'h0 : b7[7:4], b6[7:4]};
		return {15'b0, b6[3], (b5 == 8'h00), b6[0] ^ inv, size_code(b5), size_code(b4), mapper};
	endfunction

	// Header store; FDS images get a fixed mapper 20 header once loaded
	always_ff @(posedge clk) begin
		if (seq_finish) begin
			hdr_bytes[6] <= 8'h40;
			hdr_bytes[7] <= 8'h10;
			for (int i = 8; i < `HDR_LEN; i++) begin
				hdr_bytes[i] <= 8'h00;
			end
		end else if (hdr_wr) begin
			hdr_bytes[hdr_count] <= dl_data;
		end
	end

	always_comb begin
		if ({hdr_bytes[0], hdr_bytes[1], hdr_bytes[2], hdr_bytes[3]} == 32'h4E45531A)
			hdr_kind = hdr_ines; // "NES" 1A
		else if ({hdr_bytes[0], hdr_bytes[1], hdr_bytes[2], hdr_bytes[3]} == 32'h4644531A)
			hdr_kind = hdr_fds;  // "FDS" 1A
		else
			hdr_kind = hdr_unknown;
	end

	assign prg_pages = hdr_bytes[4];
	assign chr_pages = hdr_bytes[5];
	assign trainer = hdr_bytes[6][2];

	// Old tools left junk in bytes 8 to 15
	always_comb begin
		upper_nonzero = 1'b0;
		for (int i = 8; i < `HDR_LEN; i++) begin
			upper_nonzero = upper_nonzero | (hdr_bytes[i] != 8'h00);
		end
	end

	assign is_nes20 = (hdr_bytes[7][3:2] == 2'b10);
	assign is_dirty = !is_nes20 && upper_nonzero;

	assign flags_stored = build_flags(hdr_bytes[4], hdr_bytes[5], hdr_bytes[6], hdr_bytes[7],
		is_dirty, invert_mirroring);
	assign flags_fds = build_flags(hdr_bytes[4], hdr_bytes[5], 8'h40, 8'h10, 1'b0,
		invert_mirroring); // Same word the default bytes give

	always_ff @(posedge clk) begin
		if (reset)
			mapper_flags <= '0;
		else if (seq_finish)
			mapper_flags <= flags_fds;
		else
			mapper_flags <= flags_stored;
	end

endmodule

`default_nettype wire

// File: rtl/ines_pkg.sv
//******************************
// File format types: header kind, download
// file type and packed mapper flag word
//******************************
`default_nettype none

`include "nes_loader_macros.svh"

package ines_pkg;

	// Result of the magic check on header bytes 0 to 3
	typedef enum logic [1:0] {
		hdr_ines,
		hdr_fds,
		hdr_unknown
	} hdr_kind_t;

	// Download index as sent by the host
	typedef enum logic [7:0] {
		ft_game = 8'h00,
		ft_bios = `FT_BIOS,
		ft_fds = `FT_FDS
	} file_type_t;

	// Packed flags for the mapper logic
	//   [7:0] mapper, [10:8] PRG size code, [13:11] CHR size code,
	//   [14] mirroring, [15] CHR RAM, [16] four-screen
	typedef logic [31:0] mapper_flags_t;

endpackage

`default_nettype wire

// File: rtl/loader_pkg.sv
//******************************
// Machine side types: load FSM states and
// cartridge memory address
//******************************
`default_nettype none

`include "nes_loader_macros.svh"

package loader_pkg;

	// Load sequencer states
	typedef enum logic [2:0] {
		st_header, // Collecting the 16 header bytes
		st_prg,    // PRG ROM bytes
		st_chr,    // CHR ROM bytes
		st_error,  // Unsupported file
		st_raw     // FDS or BIOS image, runs until download ends
	} load_state_t;

	typedef logic [`ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

// File: rtl/mem_write_merge.sv
//******************************
// Memory write port: clock enable divider, loader
// write latch and CPU/loader source select
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "nes_loader_macros.svh"

module mem_write_merge
	import loader_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       downloading,
	input  mem_addr_t  ld_addr,
	input  logic [7:0] ld_data,
	input  logic       ld_wr,
	input  mem_addr_t  cpu_addr,
	input  logic [7:0] cpu_dout,
	input  logic       cpu_write,
	output mem_addr_t  mem_addr,
	output logic [7:0] mem_din,
	output logic       mem_we
);

	logic [`CE_PHASE_W-1:0] ce_phase;
	logic ce_last; // Last phase of the console cycle
	logic pending;
	mem_addr_t lat_addr;
	logic [7:0] lat_data;

	// Free running divider, the console steps once per wrap
	always_ff @(posedge clk) begin
		if (reset)
			ce_phase <= '0;
		else
			ce_phase <= ce_phase + `CE_PHASE_W'(1);
	end

	assign ce_last = &ce_phase;

	// Hold one loader write until the console phase lets it through
	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
		end else begin
			if (ce_last)
				pending <= 1'b0;
			if (ld_wr)
				pending <= 1'b1; // A new strobe wins over the clear
		end
	end

	always_ff @(posedge clk) begin
		if (ld_wr) begin
			lat_addr <= ld_addr;
			lat_data <= ld_data;
		end
	end

	assign mem_addr = downloading ? lat_addr : cpu_addr;
	assign mem_din = downloading ? lat_data : cpu_dout;
	assign mem_we = ce_last && (downloading ? pending : cpu_write);

endmodule

`default_nettype wire

// File: rtl/nes_loader.sv
//******************************
// Cartridge loader top: header decoder, load
// sequencer and memory write merge
//******************************
`timescale 1ns/1ps
`default_nettype none

module nes_loader
	import ines_pkg::*;
	import loader_pkg::*;
(
	input  logic          clk,
	input  logic          reset,
	input  logic          downloading,
	input  file_type_t    file_type,
	input  logic [7:0]    dl_data,
	input  logic          dl_wr,
	input  logic          invert_mirroring,
	input  mem_addr_t     cpu_addr,
	input  logic [7:0]    cpu_dout,
	input  logic          cpu_write,
	output mem_addr_t     mem_addr,
	output logic [7:0]    mem_din,
	output logic          mem_we,
	output mapper_flags_t mapper_flags,
	output logic          load_done,
	output logic          load_error
);

	logic hdr_wr;
	logic [3:0] hdr_count;
	logic seq_finish;
	hdr_kind_t hdr_kind;
	logic [7:0] prg_pages;
	logic [7:0] chr_pages;
	logic trainer;
	mem_addr_t ld_addr;
	logic [7:0] ld_data;
	logic ld_wr;

	ines_header_decoder decoder_i (
		.clk(clk),
		.reset(reset),
		.dl_data(dl_data),
		.hdr_wr(hdr_wr),
		.hdr_count(hdr_count),
		.seq_finish(seq_finish),
		.invert_mirroring(invert_mirroring),
		.hdr_kind(hdr_kind),
		.prg_pages(prg_pages),
		.chr_pages(chr_pages),
		.trainer(trainer),
		.mapper_flags(mapper_flags)
	);

	// Sees the same byte stream as the decoder
	rom_load_sequencer sequencer_i (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.file_type(file_type),
		.dl_data(dl_data),
		.dl_wr(dl_wr),
		.hdr_kind(hdr_kind),
		.trainer(trainer),
		.prg_pages(prg_pages),
		.chr_pages(chr_pages),
		.hdr_wr(hdr_wr),
		.hdr_count(hdr_count),
		.seq_finish(seq_finish),
		.ld_addr(ld_addr),
		.ld_data(ld_data),
		.ld_wr(ld_wr),
		.load_done(load_done),
		.load_error(load_error)
	);

	mem_write_merge merge_i (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.ld_addr(ld_addr),
		.ld_data(ld_data),
		.ld_wr(ld_wr),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.cpu_write(cpu_write),
		.mem_addr(mem_addr),
		.mem_din(mem_din),
		.mem_we(mem_we)
	);

endmodule

`default_nettype wire

// File: rtl/nes_loader_macros.svh
//******************************
// Loader constants: memory map, file type codes,
// header length and counter widths
//******************************
`ifndef NES_LOADER_MACROS_SVH
`define NES_LOADER_MACROS_SVH

// Cartridge memory address width
`define ADDR_W 22

`define HDR_LEN 16 // iNES header bytes

// Memory map
`define PRG_BASE 22'h000000
`define CHR_BASE 22'h200000
`define FDS_BASE 22'h010010     // FDS image, header skipped
`define FDS_RAW_BASE 22'h010020 // FDS image without header
`define BIOS_BASE 22'h000010    // BIOS data, header skipped

// Download index codes
`define FT_BIOS 8'h0A
`define FT_FDS 8'h0B

`define CE_PHASE_W 2 // Console runs at clk/4

// Page sizes as shifts
`define PRG_PAGE_SHIFT 14 // 16 KiB
`define CHR_PAGE_SHIFT 13 // 8 KiB

`endif

// File: rtl/rom_load_sequencer.sv
//******************************
// Load sequencer: header, PRG, CHR and raw image
// phases with address and byte counters
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "nes_loader_macros.svh"

module rom_load_sequencer
	import ines_pkg::*;
	import loader_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       downloading,
	input  file_type_t file_type,
	input  logic [7:0] dl_data,
	input  logic       dl_wr,
	input  hdr_kind_t  hdr_kind,
	input  logic       trainer,
	input  logic [7:0] prg_pages,
	input  logic [7:0] chr_pages,
	output logic       hdr_wr,
	output logic [3:0] hdr_count,
	output logic       seq_finish,
	output mem_addr_t  ld_addr,
	output logic [7:0] ld_data,
	output logic       ld_wr,
	output logic       load_done,
	output logic       load_error
);

	load_state_t state;
	logic [`ADDR_W-1:0] bytes_left; // Remaining ROM bytes in st_prg and st_chr
	logic rom_phase;
	logic stream_phase;

	assign rom_phase = (state == st_prg) || (state == st_chr);
	assign stream_phase = (state == st_header) || (state == st_raw);

	assign hdr_wr = dl_wr && (state == st_header);
	assign ld_data = dl_data;
	assign ld_wr = dl_wr && ((rom_phase && (bytes_left != '0)) || (stream_phase && downloading));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_header;
			hdr_count <= 4'd0;
			bytes_left <= '0;
			seq_finish <= 1'b0;
			load_done <= 1'b0;
			load_error <= 1'b0;
			ld_addr <= (file_type == ft_fds) ? `FDS_RAW_BASE : `PRG_BASE;
		end else begin
			seq_finish <= 1'b0;
			case (state)
				st_header: if (dl_wr) begin
					hdr_count <= hdr_count + 4'd1;
					ld_addr <= ld_addr + mem_addr_t'(1);
					if (hdr_count == 4'd15) begin
						// Bytes 0 to 14 are stored, so the verdict is ready
						if (hdr_kind == hdr_ines && !trainer) begin
							state <= st_prg;
							ld_addr <= `PRG_BASE;
							bytes_left <= mem_addr_t'(prg_pages) << `PRG_PAGE_SHIFT;
						end else if (hdr_kind == hdr_fds) begin
							state <= st_raw;
							ld_addr <= `FDS_BASE;
						end else if (file_type == ft_bios) begin
							state <= st_raw;
							ld_addr <= `BIOS_BASE;
						end else if (file_type == ft_fds) begin
							state <= st_raw;
							ld_addr <= `FDS_RAW_BASE;
						end else begin
							state <= st_error;
						end
					end
				end
				st_prg: begin
					if (bytes_left != '0) begin
						if (dl_wr) begin
							bytes_left <= bytes_left - mem_addr_t'(1);
							ld_addr <= ld_addr + mem_addr_t'(1);
						end
					end else begin
						state <= st_chr; // CHR follows PRG in the file
						ld_addr <= `CHR_BASE;
						bytes_left <= mem_addr_t'(chr_pages) << `CHR_PAGE_SHIFT;
					end
				end
				st_chr: begin
					if (bytes_left != '0) begin
						if (dl_wr) begin
							bytes_left <= bytes_left - mem_addr_t'(1);
							ld_addr <= ld_addr + mem_addr_t'(1);
						end
					end else begin
						load_done <= 1'b1;
					end
				end
				st_error: begin
					load_done <= 1'b1;
					load_error <= 1'b1;
				end
				st_raw: begin
					if (downloading) begin
						if (dl_wr)
							ld_addr <= ld_addr + mem_addr_t'(1);
					end else begin
						// One finish pulse, then done on the next cycle
						if (!seq_finish && !load_done)
							seq_finish <= 1'b1;
						if (seq_finish)
							load_done <= 1'b1;
					end
				end
				default: state <= st_error;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the nes_loader testbench with Verilator, runs it and searches the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_nes_loader -f nes_loader.f \
	&& ./obj_dir/Vtb_nes_loader > sim.log 2>&1 \
	|| echo "Build or simulation returned an error status"

[ -f sim.log ] && cat sim.log
grep -qx "Test OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: tb/tb_loader_tasks.svh
//******************************
// Testbench helpers: failure stop, xorshift
// generator, byte stream driver, typed compares
//******************************
`ifndef TB_LOADER_TASKS_SVH
`define TB_LOADER_TASKS_SVH

// Prints the reason and ends the run
task automatic fail_run(input string msg);
	$display("%s", msg);
	$display("Test FAILED");
	$fatal(1, "stopped on the first failure");
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// One download strobe, then idle long enough for the write port to drain
task automatic send_byte(input logic [7:0] data);
	dl_data <= data;
	dl_wr <= 1'b1;
	sent_q.push_back(data);
	@(posedge clk);
	dl_wr <= 1'b0;
	repeat (4) @(posedge clk); // 5 cycles per strobe
endtask

task automatic stream_header();
	int i;
	for (i = 0; i < 16; i++)
		send_byte(hdr[i]);
endtask

task automatic stream_payload(input int count);
	int i;
	for (i = 0; i < count; i++) begin
		rand_state = xorshift32(rand_state);
		send_byte(rand_state[7:0]);
	end
endtask

task automatic check_addr(input string what, input mem_addr_t actual, input mem_addr_t expected);
	if (actual !== expected)
		fail_run($sformatf("** Error at %0d ns: %s is %h, expected %h",
			$time, what, actual, expected));
endtask

task automatic check_byte(input string what, input logic [7:0] actual,
		input logic [7:0] expected);
	if (actual !== expected)
		fail_run($sformatf("** Error at %0d ns: %s is %h, expected %h",
			$time, what, actual, expected));
endtask

task automatic check_flags(input string what, input mapper_flags_t actual,
		input mapper_flags_t expected);
	if (actual !== expected)
		fail_run($sformatf("** Error at %0d ns: %s are %h, expected %h",
			$time, what, actual, expected));
endtask

task automatic check_bit(input string what, input logic actual, input logic expected);
	if (actual !== expected)
		fail_run($sformatf("** Error at %0d ns: %s is %b, expected %b",
			$time, what, actual, expected));
endtask

`endif

// File: tb/tb_nes_loader.sv
//******************************
// Loader testbench: clock, reset, DUT, write
// monitor, timeout and directed tests
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "nes_loader_macros.svh"

module tb_nes_loader
	import ines_pkg::*;
	import loader_pkg::*;
();

	localparam int stream_bytes = (16 + 24576) + 2 * (16 + 4) + (16 + 81920) + (16 + 40);
	localparam int timeout_cycles = stream_bytes * 6 + 2000;

	logic clk = 1'b0;
	logic reset;
	logic downloading;
	file_type_t file_type;
	logic [7:0] dl_data;
	logic dl_wr;
	logic invert_mirroring;
	mem_addr_t cpu_addr;
	logic [7:0] cpu_dout;
	logic cpu_write;
	mem_addr_t mem_addr;
	logic [7:0] mem_din;
	logic mem_we;
	mapper_flags_t mapper_flags;
	logic load_done;
	logic load_error;

	mem_addr_t wr_addr_q[$]; // Writes seen on the memory port
	logic [7:0] wr_data_q[$];
	logic [7:0] sent_q[$];   // Every byte streamed since reset
	logic [7:0] hdr [16];
	logic [31:0] rand_state = 32'hcb561d7a;
	int cycle_count;
	int last_we_cycle = -100;

	nes_loader dut_i (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.file_type(file_type),
		.dl_data(dl_data),
		.dl_wr(dl_wr),
		.invert_mirroring(invert_mirroring),
		.cpu_addr(cpu_addr),
		.cpu_dout(cpu_dout),
		.cpu_write(cpu_write),
		.mem_addr(mem_addr),
		.mem_din(mem_din),
		.mem_we(mem_we),
		.mapper_flags(mapper_flags),
		.load_done(load_done),
		.load_error(load_error)
	);

	always #10 clk = ~clk;

	`include "tb_loader_tasks.svh"

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > timeout_cycles)
			fail_run($sformatf("Timed out after %0d cycles with tests still running",
				cycle_count));
	end

	// Records each memory write and watches the write spacing
	always @(negedge clk) begin
		if (mem_we) begin
			if (cycle_count - last_we_cycle < 4)
				fail_run("Two memory writes came less than 4 cycles apart");
			last_we_cycle = cycle_count;
			wr_addr_q.push_back(mem_addr);
			wr_data_q.push_back(mem_din);
		end
	end

	task automatic reset_dut();
		reset <= 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_bit("load_done after reset", load_done, 1'b0);
		check_bit("load_error after reset", load_error, 1'b0);
		@(posedge clk);
		wr_addr_q.delete();
		wr_data_q.delete();
		sent_q.delete();
	endtask

	task automatic make_header(input logic [31:0] magic, input logic [7:0] prg,
			input logic [7:0] chr, input logic [7:0] b6, input logic [7:0] b7,
			input logic [7:0] junk);
		int i;
		for (i = 0; i < 16; i++)
			hdr[i] = 8'h00;
		hdr[0] = magic[31:24];
		hdr[1] = magic[23:16];
		hdr[2] = magic[15:8];
		hdr[3] = magic[7:0];
		hdr[4] = prg;
		hdr[5] = chr;
		hdr[6] = b6;
		hdr[7] = b7;
		hdr[9] = junk; // Nonzero makes an old style dirty header
	endtask

	// Flag word from the header bytes held in hdr
	function automatic mapper_flags_t expected_flags(input logic inv);
		mapper_flags_t f;
		logic [7:0] junk;
		logic nes20;
		int prg_code;
		int chr_code;
		int i;
		junk = 8'h00;
		for (i = 8; i < 16; i++)
			junk = junk | hdr[i];
		nes20 = (hdr[7][3:2] == 2'b10);
		prg_code = 0;
		while (prg_code < 7 && (1 << prg_code) < int'(hdr[4]))
			prg_code++;
		chr_code = 0;
		while (chr_code < 7 && (1 << chr_code) < int'(hdr[5]))
			chr_code++;
		f = '0;
		f[3:0] = hdr[6][7:4];
		f[7:4] = (!nes20 && junk != 8'h00) ? 4'h0 : hdr[7][7:4];
		f[10:8] = prg_code[2:0];
		f[13:11] = chr_code[2:0];
		f[14] = hdr[6][0] ^ inv;
		f[15] = (hdr[5] == 8'h00);
		f[16] = hdr[6][3];
		return f;
	endfunction

	task automatic wait_done(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (load_done !== 1'b1 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (load_done !== 1'b1)
			fail_run("load_done never rose after the end of the file");
		@(posedge clk);
	endtask

	// Pops count writes, expected at base upward with the streamed bytes in order
	task automatic expect_run(input mem_addr_t base, input int count);
		int i;
		for (i = 0; i < count; i++) begin
			if (wr_addr_q.size() == 0)
				fail_run($sformatf("Write %0d of the run at %h never reached memory", i, base));
			check_addr("write address", wr_addr_q.pop_front(), base + mem_addr_t'(i));
			check_byte("write data", wr_data_q.pop_front(), sent_q.pop_front());
		end
	endtask

	task automatic expect_quiet();
		if (wr_addr_q.size() != 0)
			fail_run($sformatf("Memory saw %0d writes beyond the expected ones",
				wr_addr_q.size()));
	endtask

	task automatic expect_rejected();
		wait_done(50);
		check_bit("load_error", load_error, 1'b1);
		stream_payload(4); // Ignored after the error
		expect_run(`PRG_BASE, 16);
		expect_quiet();
		downloading <= 1'b0;
	endtask

	task automatic test_ines_load();
		file_type <= ft_game;
		invert_mirroring <= 1'b0;
		reset_dut();
		downloading <= 1'b1;
		make_header(32'h4E45531A, 8'h01, 8'h01, 8'h41, 8'h00, 8'h00); // Mapper 4
		stream_header();
		stream_payload(24576);
		wait_done(50);
		check_bit("load_error", load_error, 1'b0);
		check_flags("mapper flags", mapper_flags, expected_flags(1'b0));
		expect_run(`PRG_BASE, 16);
		expect_run(`PRG_BASE, 16384);
		expect_run(`CHR_BASE, 8192);
		expect_quiet();
		downloading <= 1'b0;
	endtask

	task automatic test_bad_header();
		file_type <= ft_game;
		reset_dut();
		downloading <= 1'b1;
		make_header(32'h4E45581A, 8'h01, 8'h01, 8'h00, 8'h00, 8'h00); // "NEX" 1A
		stream_header();
		expect_rejected();
	endtask

	task automatic test_trainer_rejected();
		file_type <= ft_game;
		reset_dut();
		downloading <= 1'b1;
		make_header(32'h4E45531A, 8'h01, 8'h01, 8'h04, 8'h00, 8'h00);
		stream_header();
		expect_rejected();
	endtask

	task automatic test_flag_rules();
		file_type <= ft_game;
		invert_mirroring <= 1'b1;
		reset_dut();
		downloading <= 1'b1;
		make_header(32'h4E45531A, 8'h05, 8'h00, 8'h10, 8'h30, 8'h55);
		stream_header();
		stream_payload(5 * 16384);
		wait_done(50);
		check_bit("load_error", load_error, 1'b0);
		check_flags("mapper flags", mapper_flags, expected_flags(1'b1));
		check_byte("mapper number", mapper_flags[7:0], 8'h01);
		check_byte("PRG size code", {5'b0, mapper_flags[10:8]}, 8'd3);
		check_bit("CHR RAM flag", mapper_flags[15], 1'b1);
		check_bit("mirroring flag", mapper_flags[14], 1'b1);
		expect_run(`PRG_BASE, 16);
		expect_run(`PRG_BASE, 5 * 16384);
		expect_quiet();
		downloading <= 1'b0;
		invert_mirroring <= 1'b0;
	endtask

	task automatic test_fds_raw();
		file_type <= ft_fds;
		invert_mirroring <= 1'b1;
		reset_dut();
		downloading <= 1'b1;
		make_header(32'h4644531A, 8'h01, 8'h00, 8'h00, 8'h00, 8'h00); // "FDS" 1A
		stream_header();
		stream_payload(40);
		downloading <= 1'b0;
		wait_done(50);
		check_bit("load_error", load_error, 1'b0);
		expect_run(`FDS_RAW_BASE, 16);
		expect_run(`FDS_BASE, 40);
		expect_quiet();
		// Default bytes 6 and 7 replace the streamed ones
		make_header(32'h4644531A, 8'h01, 8'h00, 8'h40, 8'h10, 8'h00);
		check_flags("FDS mapper flags", mapper_flags, expected_flags(1'b1));
		check_byte("mapper number", mapper_flags[7:0], 8'd20);
		check_bit("mirroring flag", mapper_flags[14], 1'b1);
		file_type <= ft_game;
		invert_mirroring <= 1'b0;
	endtask

	task automatic test_cpu_path();
		mem_addr_t addr;
		logic [7:0] data;
		int i;
		file_type <= ft_game;
		reset_dut();
		downloading <= 1'b0;
		for (i = 0; i < 3; i++) begin
			rand_state = xorshift32(rand_state);
			addr = rand_state[21:0];
			data = rand_state[29:22];
			cpu_addr <= addr;
			cpu_dout <= data;
			cpu_write <= 1'b1;
			repeat (4) @(posedge clk); // Held for one clock enable period
			cpu_write <= 1'b0;
			repeat (3) @(posedge clk);
			if (wr_addr_q.size() != 1)
				fail_run($sformatf("CPU write %0d reached memory %0d times instead of once",
					i, wr_addr_q.size()));
			check_addr("CPU write address", wr_addr_q.pop_front(), addr);
			check_byte("CPU write data", wr_data_q.pop_front(), data);
		end
	endtask

	initial begin
		reset <= 1'b1;
		downloading <= 1'b0;
		file_type <= ft_game;
		dl_data <= 8'h00;
		dl_wr <= 1'b0;
		invert_mirroring <= 1'b0;
		cpu_addr <= '0;
		cpu_dout <= 8'h00;
		cpu_write <= 1'b0;
		test_ines_load();
		test_bad_header();
		test_trainer_rejected();
		test_flag_rules();
		test_fds_raw();
		test_cpu_path();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire
